// File: compile.f
common/rv_pkg.sv
common/dec_if.sv
common/ret_if.sv
decode/key_mux.sv
decode/op_decoder.sv
decode/inst_decoder.sv
design/inst_latch.sv
design/reg_file.sv
design/exec_unit.sv
design/retire_stage.sv
design/rv_slice_top.sv
dv/rv_slice_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module rv_slice_tb -o rv_slice_sim

./obj_dir/rv_slice_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
grep -q "TEST PASSED" sim.log

// File: dv/rv_slice_tb.sv
`default_nettype none

module rv_slice_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        rd_wen;
    logic [31:0] wdata;
    logic [31:0] next_pc;
    logic        mem_valid;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    lsu_op_e     lsu;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        out_valid;
  logic [31:0] out_pc;
  logic [4:0]  out_rd;
  logic        out_rd_wen;
  logic [31:0] out_wdata;
  logic [31:0] out_next_pc;
  logic        out_mem_valid;
  logic        out_mem_we;
  logic [31:0] out_mem_addr;
  logic [31:0] out_mem_wdata;
  lsu_op_e     out_lsu_op;

  entry_t      rows [$];
  entry_t      sb_q [$];   // Issued, not yet retired
  logic [31:0] shadow [32];

  rv_slice_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .inst_pc       (inst_pc),
    .out_valid     (out_valid),
    .out_pc        (out_pc),
    .out_rd        (out_rd),
    .out_rd_wen    (out_rd_wen),
    .out_wdata     (out_wdata),
    .out_next_pc   (out_next_pc),
    .out_mem_valid (out_mem_valid),
    .out_mem_we    (out_mem_we),
    .out_mem_addr  (out_mem_addr),
    .out_mem_wdata (out_mem_wdata),
    .out_lsu_op    (out_lsu_op)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Everything inactive, falls through to pc+4
  function automatic entry_t blank_row(input logic [31:0] code, input logic [31:0] pc);
    entry_t e;
    e.inst      = code;
    e.pc        = pc;
    e.rd        = 5'd0;
    e.rd_wen    = 1'b0;
    e.wdata     = 32'd0;
    e.next_pc   = pc + 32'd4;
    e.mem_valid = 1'b0;
    e.mem_we    = 1'b0;
    e.mem_addr  = 32'd0;
    e.mem_wdata = 32'd0;
    e.lsu       = LSU_NONE;
    return e;
  endfunction

  function automatic void jmp_row(input logic [31:0] code, input logic [31:0] pc,
      input logic [4:0] rd, input logic [31:0] wdata, input logic [31:0] npc);
    entry_t e;
    e = blank_row(code, pc);
    e.rd      = rd;
    e.rd_wen  = 1'b1;
    e.wdata   = wdata;
    e.next_pc = npc;
    rows.push_back(e);
    if (rd != 5'd0) shadow[rd] = wdata;  // x0 keeps zero
  endfunction

  function automatic void alu_row(input logic [31:0] code, input logic [31:0] pc,
      input logic [4:0] rd, input logic [31:0] wdata);
    jmp_row(code, pc, rd, wdata, pc + 32'd4);
  endfunction

  function automatic void br_row(input logic [31:0] code, input logic [31:0] pc,
      input logic [31:0] npc);
    entry_t e;
    e = blank_row(code, pc);
    e.next_pc = npc;
    rows.push_back(e);
  endfunction

  function automatic void mem_row(input logic [31:0] code, input logic [31:0] pc,
      input logic we, input logic [31:0] addr, input logic [31:0] wdata, input lsu_op_e lsu);
    entry_t e;
    e = blank_row(code, pc);
    e.mem_valid = 1'b1;
    e.mem_we    = we;
    e.mem_addr  = addr;
    e.mem_wdata = wdata;
    e.lsu       = lsu;
    rows.push_back(e);
  endfunction

  function automatic void build_table();
    alu_row(r_type(7'h00, 5'd21, 5'd20, 3'b000, 5'd19), 32'h100, 5'd19, 32'h0);  // Fresh regs
    alu_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 32'h104, 5'd1, 32'h5);
    alu_row(i_type(-12'sd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 32'h108, 5'd2, 32'hFFFF_FFFD);
    alu_row(i_type(12'd0, 5'd2, 3'b010, 5'd3, OPC_OP_IMM), 32'h10C, 5'd3, 32'h1);  // SLTI
    alu_row(i_type(12'h00F, 5'd1, 3'b100, 5'd4, OPC_OP_IMM), 32'h110, 5'd4, 32'hA);
    alu_row(i_type(12'd4, 5'd1, 3'b001, 5'd5, OPC_OP_IMM), 32'h114, 5'd5, 32'h50);
    alu_row(i_type(12'h401, 5'd2, 3'b101, 5'd6, OPC_OP_IMM), 32'h118, 5'd6, 32'hFFFF_FFFE);
    alu_row(r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd7), 32'h11C, 5'd7, 32'h55);      // ADD
    alu_row(r_type(7'h20, 5'd1, 5'd7, 3'b000, 5'd8), 32'h120, 5'd8, 32'h50);      // SUB
    alu_row(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd9), 32'h124, 5'd9, 32'h1);       // SLTU
    alu_row(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd10), 32'h128, 5'd10, 32'hFFFF_FFFE);
    alu_row(r_type(7'h00, 5'd7, 5'd2, 3'b111, 5'd11), 32'h12C, 5'd11, 32'h55);    // AND
    alu_row(u_type(20'h12345, 5'd12, OPC_LUI), 32'h130, 5'd12, 32'h1234_5000);
    alu_row(u_type(20'h00001, 5'd13, OPC_AUIPC), 32'h134, 5'd13, 32'h1134);
    br_row(b_type(13'd16, 5'd1, 5'd1, 3'b000), 32'h138, 32'h148);    // BEQ taken
    br_row(b_type(13'd8, 5'd1, 5'd1, 3'b001), 32'h13C, 32'h140);     // BNE not taken
    br_row(b_type(-13'sd8, 5'd1, 5'd2, 3'b100), 32'h140, 32'h138);   // BLT taken backwards
    br_row(b_type(13'd12, 5'd2, 5'd1, 3'b111), 32'h144, 32'h148);    // BGEU not taken
    jmp_row(j_type(21'h20, 5'd14), 32'h148, 5'd14, 32'h14C, 32'h168);
    jmp_row(i_type(12'h010, 5'd1, 3'b000, 5'd15, OPC_JALR), 32'h14C, 5'd15, 32'h150, 32'h14);
    mem_row(s_type(12'd8, 5'd7, 5'd1, 3'b010), 32'h150, 1'b1, 32'hD, 32'h55, LSU_SW);
    mem_row(s_type(-12'sd1, 5'd2, 5'd5, 3'b000), 32'h154, 1'b1, 32'h4F, 32'hFFFF_FFFD, LSU_SB);
    mem_row(i_type(12'd4, 5'd5, 3'b010, 5'd16, OPC_LOAD), 32'h158, 1'b0, 32'h54, 32'h0, LSU_LW);
    mem_row(i_type(12'd0, 5'd1, 3'b100, 5'd17, OPC_LOAD), 32'h15C, 1'b0, 32'h5, 32'h0, LSU_LBU);
    alu_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 32'h160, 5'd0, 32'hC);  // To x0
    alu_row(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd18), 32'h164, 5'd18, 32'h5);
    rows.push_back(blank_row(32'h0000_000F, 32'h168));  // FENCE
    rows.push_back(blank_row(32'h0000_0073, 32'h16C));  // ECALL
    br_row(b_type(13'd16, 5'd2, 5'd1, 3'b000), 32'h170, 32'h174);    // BEQ not taken
    br_row(b_type(13'd8, 5'd2, 5'd1, 3'b001), 32'h174, 32'h17C);     // BNE taken
    br_row(b_type(-13'sd8, 5'd2, 5'd1, 3'b100), 32'h178, 32'h17C);   // BLT not taken
    br_row(b_type(13'd12, 5'd1, 5'd2, 3'b111), 32'h17C, 32'h188);    // BGEU taken
  endfunction

  task automatic drive_rows();
    foreach (rows[i]) begin
      @(negedge clk);
      inst_valid = 1'b1;
      inst       = rows[i].inst;
      inst_pc    = rows[i].pc;
      sb_q.push_back(rows[i]);
    end
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic wait_result(output int waited);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_valid && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_valid) abort_run("timeout: no out_valid within 20 cycles");
    waited = cycles;
  endtask

  task automatic compare_result(input entry_t e);
    check("out_pc", out_pc, e.pc);
    check("out_rd_wen", 32'(out_rd_wen), 32'(e.rd_wen));
    if (e.rd_wen) begin
      check("out_rd", 32'(out_rd), 32'(e.rd));
      check("out_wdata", out_wdata, e.wdata);
    end
    check("out_next_pc", out_next_pc, e.next_pc);
    check("out_mem_valid", 32'(out_mem_valid), 32'(e.mem_valid));
    check("out_mem_we", 32'(out_mem_we), 32'(e.mem_we));
    if (e.mem_valid) check("out_mem_addr", out_mem_addr, e.mem_addr);
    if (e.mem_we) check("out_mem_wdata", out_mem_wdata, e.mem_wdata);
    check("out_lsu_op", 32'(out_lsu_op), 32'(e.lsu));
  endtask

  task automatic collect_results(input int n);
    entry_t e;
    int     waited;
    for (int i = 0; i < n; i++) begin
      wait_result(waited);
      // Back-to-back issue must retire one result per cycle
      if (i > 0 && waited != 0)
        abort_run("pipeline stalled: results did not retire one per cycle");
      if (sb_q.size() == 0) abort_run("out_valid seen with no instruction outstanding");
      e = sb_q.pop_front();
      compare_result(e);
    end
  endtask

  initial begin
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm;
    void'($urandom(32'h998e));
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = 32'd0;
    inst_pc    = 32'd0;
    foreach (shadow[i]) shadow[i] = 32'd0;
    build_table();
    // Random ADDI burst continues from the shadow state left by the table
    pc = 32'h180;
    for (int k = 0; k < 40; k++) begin
      rd  = 5'($urandom);
      rs1 = 5'($urandom);
      imm = 12'($urandom);
      alu_row(i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM), pc, rd,
              shadow[rs1] + {{20{imm[11]}}, imm});
      pc = pc + 32'd4;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check("out_valid", 32'(out_valid), 32'd0);
    check("out_rd_wen", 32'(out_rd_wen), 32'd0);
    check("out_mem_valid", 32'(out_mem_valid), 32'd0);
    check("out_mem_we", 32'(out_mem_we), 32'd0);
    fork
      drive_rows();
      collect_results(rows.size());
    join
    repeat (3) begin
      @(negedge clk);
      check("out_valid", 32'(out_valid), 32'd0);  // Nothing left in flight
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/rv_slice_top.sv
`default_nettype none

module rv_slice_top import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              inst_valid,
  input  logic [31:0]       inst,
  input  logic [XLEN-1:0]   inst_pc,
  output logic              out_valid,
  output logic [XLEN-1:0]   out_pc,
  output logic [REG_AW-1:0] out_rd,
  output logic              out_rd_wen,
  output logic [XLEN-1:0]   out_wdata,
  output logic [XLEN-1:0]   out_next_pc,
  output logic              out_mem_valid,
  output logic              out_mem_we,
  output logic [XLEN-1:0]   out_mem_addr,
  output logic [XLEN-1:0]   out_mem_wdata,
  output lsu_op_e           out_lsu_op
);

  logic            q_valid;
  logic [31:0]     q_inst;
  logic [XLEN-1:0] q_pc;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  dec_if dec_bus ();
  ret_if ret_bus ();

  inst_latch u_latch (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .q_valid    (q_valid),
    .q_inst     (q_inst),
    .q_pc       (q_pc)
  );

  inst_decoder u_dec (
    .valid (q_valid),
    .inst  (q_inst),
    .pc    (q_pc),
    .dec   (dec_bus.src)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec_bus.rs1),
    .rs2      (dec_bus.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (ret_bus.dst)
  );

  exec_unit u_exec (
    .dec      (dec_bus.dst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ret      (ret_bus.src)
  );

  retire_stage u_retire (
    .clk           (clk),
    .rst_n         (rst_n),
    .ret           (ret_bus.dst),
    .lsu_op        (dec_bus.lsu_op),
    .out_valid     (out_valid),
    .out_pc        (out_pc),
    .out_rd        (out_rd),
    .out_rd_wen    (out_rd_wen),
    .out_wdata     (out_wdata),
    .out_next_pc   (out_next_pc),
    .out_mem_valid (out_mem_valid),
    .out_mem_we    (out_mem_we),
    .out_mem_addr  (out_mem_addr),
    .out_mem_wdata (out_mem_wdata),
    .out_lsu_op    (out_lsu_op)
  );

endmodule

`default_nettype wire

// File: design/retire_stage.sv
`default_nettype none

module retire_stage import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  ret_if.dst                ret,
  input  lsu_op_e           lsu_op,
  output logic              out_valid,
  output logic [XLEN-1:0]   out_pc,
  output logic [REG_AW-1:0] out_rd,
  output logic              out_rd_wen,
  output logic [XLEN-1:0]   out_wdata,
  output logic [XLEN-1:0]   out_next_pc,
  output logic              out_mem_valid,
  output logic              out_mem_we,
  output logic [XLEN-1:0]   out_mem_addr,
  output logic [XLEN-1:0]   out_mem_wdata,
  output lsu_op_e           out_lsu_op
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid     <= 1'b0;
      out_rd_wen    <= 1'b0;
      out_mem_valid <= 1'b0;
      out_mem_we    <= 1'b0;
    end else begin
      out_valid     <= ret.valid;
      out_rd_wen    <= ret.valid && ret.rd_wen;   // Strobes only with a live result
      out_mem_valid <= ret.valid && ret.mem_valid;
      out_mem_we    <= ret.valid && ret.mem_we;
    end
  end

  always_ff @(posedge clk) begin
    if (ret.valid) begin
      out_pc        <= ret.pc;
      out_rd        <= ret.rd;
      out_wdata     <= ret.wdata;
      out_next_pc   <= ret.next_pc;
      out_mem_addr  <= ret.mem_addr;
      out_mem_wdata <= ret.mem_wdata;
      out_lsu_op    <= lsu_op;
    end
  end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`default_nettype none

module exec_unit import rv_pkg::*; (
  dec_if.dst             dec,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  ret_if.src             ret
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_tgt;
  logic [4:0]      shamt;
  logic            taken;
  logic            is_store;

  assign op_a  = dec.src_sel[1] ? dec.pc  : rs1_data;
  assign op_b  = dec.src_sel[0] ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  taken = (rs1_data == rs2_data);                   // BEQ
      3'b001:  taken = (rs1_data != rs2_data);                   // BNE
      3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // BLT
      3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
      3'b110:  taken = (rs1_data < rs2_data);                    // BLTU
      3'b111:  taken = (rs1_data >= rs2_data);                   // BGEU
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4 = dec.pc + 32'd4;
  assign jalr_tgt = (rs1_data + dec.imm) & ~32'd1;
  assign is_store = dec.lsu_op inside {LSU_SB, LSU_SH, LSU_SW};

  assign ret.valid     = dec.valid;
  assign ret.pc        = dec.pc;
  assign ret.rd        = dec.rd;
  assign ret.rd_wen    = dec.rd_wen;
  assign ret.wdata     = (dec.jal || dec.jalr) ? pc_plus4 : alu_res;  // Link value
  assign ret.next_pc   = dec.jalr ? jalr_tgt :
                         ((dec.branch && taken) || dec.jal) ? dec.pc + dec.imm : pc_plus4;
  assign ret.mem_valid = (dec.lsu_op != LSU_NONE);
  assign ret.mem_we    = is_store;
  assign ret.mem_addr  = rs1_data + dec.imm;
  assign ret.mem_wdata = rs2_data;

  // Decode table and memory path must never both claim the result
  always_comb begin
    assert (!(ret.mem_valid && ret.rd_wen)) else $error("exec_unit: mem op with rd write");
  end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  output logic [XLEN-1:0]   rs1_data,
  output logic [XLEN-1:0]   rs2_data,
  ret_if.dst                wr
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr.valid && wr.rd_wen && wr.rd != '0) begin
      regs[wr.rd] <= wr.wdata;
    end
  end

  // Entry 0 is never written, so x0 reads zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

`default_nettype wire

// File: design/inst_latch.sv
`default_nettype none

module inst_latch import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            inst_valid,
  input  logic [31:0]     inst,
  input  logic [XLEN-1:0] inst_pc,
  output logic            q_valid,
  output logic [31:0]     q_inst,
  output logic [XLEN-1:0] q_pc
);

  always_ff @(posedge clk) begin
    if (!rst_n) q_valid <= 1'b0;
    else        q_valid <= inst_valid;
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      q_inst <= inst;
      q_pc   <= inst_pc;
    end
  end

  a_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !q_valid);

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`default_nettype none

module inst_decoder import rv_pkg::*; (
  input  logic            valid,
  input  logic [31:0]     inst,
  input  logic [XLEN-1:0] pc,
  dec_if.src              dec
);

  logic [6:0]        opcode;
  logic [REG_AW-1:0] rs1_f;
  logic [REG_AW-1:0] rs2_f;
  logic [REG_AW-1:0] rd_f;
  reg_use_t          use_vals [NR_OPC];
  reg_use_t          reg_use;
  op_ctl_t           ctl;

  assign opcode = inst[6:0];
  assign rs1_f  = inst[19:15];
  assign rs2_f  = inst[24:20];
  assign rd_f   = inst[11:7];

  // Order follows OPC_TABLE
  assign use_vals[0]  = {5'd0,  5'd0,  rd_f, 1'b1};   // LUI
  assign use_vals[1]  = {5'd0,  5'd0,  rd_f, 1'b1};   // AUIPC
  assign use_vals[2]  = {5'd0,  5'd0,  rd_f, 1'b1};   // JAL
  assign use_vals[3]  = {rs1_f, 5'd0,  rd_f, 1'b1};   // JALR
  assign use_vals[4]  = {rs1_f, rs2_f, 5'd0, 1'b0};   // BRANCH
  assign use_vals[5]  = {rs1_f, 5'd0,  rd_f, 1'b0};   // LOAD, no return data here
  assign use_vals[6]  = {rs1_f, rs2_f, 5'd0, 1'b0};   // STORE
  assign use_vals[7]  = {rs1_f, 5'd0,  rd_f, 1'b1};   // OP_IMM
  assign use_vals[8]  = {rs1_f, rs2_f, rd_f, 1'b1};   // OP
  assign use_vals[9]  = {5'd0,  5'd0,  5'd0, 1'b0};   // FENCE
  assign use_vals[10] = {rs1_f, 5'd0,  rd_f, 1'b0};   // SYS retires as no-op

  key_mux #(
    .NR_KEY    (NR_OPC),
    .KEY_LEN   (7),
    .payload_t (reg_use_t)
  ) u_reg_mux (
    .key         (opcode),
    .default_out ('0),
    .keys        (OPC_TABLE),
    .vals        (use_vals),
    .out         (reg_use)
  );

  op_decoder u_op_dec (
    .opcode (opcode),
    .funct3 (inst[14:12]),
    .funct7 (inst[31:25]),
    .ctl    (ctl)
  );

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC: dec.imm = {inst[31:12], 12'b0};
      OPC_JAL:    dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                             inst[30:21], 1'b0};
      OPC_BRANCH: dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                             inst[11:8], 1'b0};
      OPC_STORE:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      default:    dec.imm = {{20{inst[31]}}, inst[31:20]};  // I-type
    endcase
  end

  assign dec.valid   = valid;
  assign dec.pc      = pc;
  assign dec.rs1     = reg_use.rs1;
  assign dec.rs2     = reg_use.rs2;
  assign dec.rd      = reg_use.rd;
  assign dec.rd_wen  = reg_use.rd_wen;
  assign dec.alu_op  = ctl.alu_op;
  assign dec.src_sel = ctl.src_sel;
  assign dec.lsu_op  = ctl.lsu_op;
  assign dec.funct3  = inst[14:12];
  assign dec.branch  = (opcode == OPC_BRANCH);
  assign dec.jal     = (opcode == OPC_JAL);
  assign dec.jalr    = (opcode == OPC_JALR);

endmodule

`default_nettype wire

// File: decode/op_decoder.sv
`default_nettype none

module op_decoder import rv_pkg::*; (
  input  logic [6:0] opcode,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  output op_ctl_t    ctl
);

  op_ctl_t op_vals [NR_OPC];
  op_ctl_t base;
  logic    alt;

  assign op_vals[0]  = {ALU_PASS_B, SEL_RS1_IMM, LSU_NONE};  // LUI
  assign op_vals[1]  = {ALU_ADD,    SEL_PC_IMM,  LSU_NONE};  // AUIPC
  assign op_vals[2]  = {ALU_ADD,    SEL_PC_IMM,  LSU_NONE};  // JAL
  assign op_vals[3]  = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // JALR
  assign op_vals[4]  = {ALU_ADD,    SEL_PC_RS2,  LSU_NONE};  // BRANCH
  assign op_vals[5]  = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // LOAD
  assign op_vals[6]  = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // STORE
  assign op_vals[7]  = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // OP_IMM
  assign op_vals[8]  = {ALU_ADD,    SEL_RS1_RS2, LSU_NONE};  // OP
  assign op_vals[9]  = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // FENCE
  assign op_vals[10] = {ALU_ADD,    SEL_RS1_IMM, LSU_NONE};  // SYS

  key_mux #(
    .NR_KEY    (NR_OPC),
    .KEY_LEN   (7),
    .payload_t (op_ctl_t)
  ) u_op_mux (
    .key         (opcode),
    .default_out ({ALU_ADD, SEL_RS1_RS2, LSU_NONE}),
    .keys        (OPC_TABLE),
    .vals        (op_vals),
    .out         (base)
  );

  assign alt = funct7[5];

  always_comb begin
    ctl = base;
    if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
      case (funct3)
        3'b000:  ctl.alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
        3'b001:  ctl.alu_op = ALU_SLL;
        3'b010:  ctl.alu_op = ALU_SLT;
        3'b011:  ctl.alu_op = ALU_SLTU;
        3'b100:  ctl.alu_op = ALU_XOR;
        3'b101:  ctl.alu_op = alt ? ALU_SRA : ALU_SRL;
        3'b110:  ctl.alu_op = ALU_OR;
        default: ctl.alu_op = ALU_AND;
      endcase
    end
    if (opcode == OPC_LOAD) begin
      case (funct3)
        3'b000:  ctl.lsu_op = LSU_LB;
        3'b001:  ctl.lsu_op = LSU_LH;
        3'b010:  ctl.lsu_op = LSU_LW;
        3'b100:  ctl.lsu_op = LSU_LBU;
        3'b101:  ctl.lsu_op = LSU_LHU;
        default: ctl.lsu_op = LSU_NONE;
      endcase
    end else if (opcode == OPC_STORE) begin
      case (funct3)
        3'b000:  ctl.lsu_op = LSU_SB;
        3'b001:  ctl.lsu_op = LSU_SH;
        3'b010:  ctl.lsu_op = LSU_SW;
        default: ctl.lsu_op = LSU_NONE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: decode/key_mux.sv
`default_nettype none

module key_mux #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type payload_t = logic
) (
  input  logic [KEY_LEN-1:0] key,
  input  payload_t           default_out,
  input  logic [KEY_LEN-1:0] keys [NR_KEY],
  input  payload_t           vals [NR_KEY],
  output payload_t           out
);

  logic dup;

  // Walk from the back so the lowest matching entry wins
  always_comb begin
    out = default_out;
    for (int i = NR_KEY - 1; i >= 0; i--) begin
      if (key == keys[i]) out = vals[i];
    end
  end

  always_comb begin
    dup = 1'b0;
    for (int i = 0; i < NR_KEY; i++) begin
      for (int j = i + 1; j < NR_KEY; j++) begin
        if (keys[i] == keys[j]) dup = 1'b1;
      end
    end
    assert (!dup) else $error("key_mux: duplicate key in table");
  end

endmodule

`default_nettype wire

// File: common/ret_if.sv
`default_nettype none

interface ret_if import rv_pkg::*; ();
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [REG_AW-1:0] rd;
  logic              rd_wen;
  logic [XLEN-1:0]   wdata;
  logic [XLEN-1:0]   next_pc;
  logic              mem_valid;
  logic              mem_we;
  logic [XLEN-1:0]   mem_addr;
  logic [XLEN-1:0]   mem_wdata;

  modport src (output valid, pc, rd, rd_wen, wdata, next_pc, mem_valid, mem_we,
               mem_addr, mem_wdata);
  modport dst (input valid, pc, rd, rd_wen, wdata, next_pc, mem_valid, mem_we,
               mem_addr, mem_wdata);
endinterface

`default_nettype wire

// File: common/dec_if.sv
`default_nettype none

interface dec_if import rv_pkg::*; ();
  logic              valid;
  logic [XLEN-1:0]   pc;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic              rd_wen;
  logic [XLEN-1:0]   imm;
  alu_op_e           alu_op;
  src_sel_t          src_sel;
  lsu_op_e           lsu_op;
  logic [2:0]        funct3;
  logic              branch;
  logic              jal;
  logic              jalr;

  modport src (output valid, pc, rs1, rs2, rd, rd_wen, imm, alu_op, src_sel,
               lsu_op, funct3, branch, jal, jalr);

  modport dst (input valid, pc, rs1, rs2, rd, rd_wen, imm, alu_op, src_sel,
               lsu_op, funct3, branch, jal, jalr);
endinterface

`default_nettype wire

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int NR_OPC = 11;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYS    = 7'b1110011;

  // Key column shared by both decode tables
  localparam logic [6:0] OPC_TABLE [NR_OPC] = '{
    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
    OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYS
  };

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // Bit 1 picks pc for operand A, bit 0 picks imm for operand B
  typedef logic [1:0] src_sel_t;
  localparam src_sel_t SEL_RS1_RS2 = 2'b00;
  localparam src_sel_t SEL_RS1_IMM = 2'b01;
  localparam src_sel_t SEL_PC_RS2  = 2'b10;
  localparam src_sel_t SEL_PC_IMM  = 2'b11;

  typedef enum logic [3:0] {
    LSU_NONE, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU,
    LSU_SB, LSU_SH, LSU_SW
  } lsu_op_e;

  typedef struct packed {
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              rd_wen;
  } reg_use_t;

  typedef struct packed {
    alu_op_e  alu_op;
    src_sel_t src_sel;
    lsu_op_e  lsu_op;
  } op_ctl_t;

endpackage

`default_nettype wire
